// ==== common/stageId_macros.svh ====
`ifndef STAGEID_MACROS_SVH
`define STAGEID_MACROS_SVH

// Datapath widths shared by the decode stage

`define DATA_WIDTH 32   // Register data width
`define PC_WIDTH   32   // Program counter width
`define REG_WIDTH  5    // Register index width

`endif

// ==== common/rv32iPkg.sv ====
package rv32iPkg;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011
    } OpCode;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASSB                       // Result is operand B, used by LUI
    } AluOp;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,               // PC + 4
        PC_OFFSET = 2'd1,               // PC + imm
        PC_REG    = 2'd2                // (rs1 + imm) & ~1
    } PcNextSel;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,                  // ALU result
        WB_MEM = 2'd1,                  // Load data
        WB_PC4 = 2'd2                   // Link address
    } RegWrDataSel;

    // ------------------------------
    // Control word, 10 bits
    // ------------------------------
    typedef struct packed {
        logic        regWrEnable;       // Writes rd
        logic        memWrEnable;       // Store
        RegWrDataSel regWrDataSel;      // Writeback source
        logic        operandASel;       // 0 rs1, 1 PC
        logic        operandBSel;       // 0 rs2, 1 imm
        AluOp        aluOp;
    } CtrlWord;

endpackage

// ==== common/pipePkg.sv ====
package pipePkg;

    import rv32iPkg::*;

`include "stageId_macros.svh"

    typedef enum logic [1:0] {
        FWD_REGS = 2'd0,                // Register file value
        FWD_EX   = 2'd1,                // Result of the EX stage
        FWD_MEM  = 2'd2,                // EX/MEM data
        FWD_WB   = 2'd3                 // MEM/WB data
    } FwdSel;

    typedef struct packed {
        logic                  valid;
        logic [31:0]           inst;
        logic [`PC_WIDTH-1:0]  pc;
    } IfIdPayload;

    typedef struct packed {
        logic                   valid;
        OpCode                  opcode;
        logic [`REG_WIDTH-1:0]  rs1;
        logic [`REG_WIDTH-1:0]  rs2;
        logic [`REG_WIDTH-1:0]  rd;
        logic [`DATA_WIDTH-1:0] imm;
        logic [`DATA_WIDTH-1:0] dataA;  // rs1 from the register file
        logic [`DATA_WIDTH-1:0] dataB;  // rs2 from the register file
        logic [`PC_WIDTH-1:0]   pc;
        CtrlWord                ctrl;
    } IdExPayload;

    typedef struct packed {
        logic                   regWrEnable;
        logic [`REG_WIDTH-1:0]  regWrAddr;
        logic [`DATA_WIDTH-1:0] regWrData;
    } StageWrite;

endpackage

// ==== design/PipelineReg.sv ====
`timescale 1ns/1ps

module PipelineReg #(
    parameter type PayloadT = logic             // Stage payload struct
) (
    input  logic    i_Clock,
    input  logic    i_rstN,
    input  logic    i_Hold,                     // Stall, keep current item
    input  PayloadT i_Data,
    output PayloadT o_Data
);

    // An invalid input item passes as a bubble, its valid bit already 0
    always_ff @(posedge i_Clock) begin
        if (!i_rstN)
            o_Data <= '0;                       // Clears valid and control
        else if (!i_Hold)
            o_Data <= i_Data;                   // Advance one item
    end

endmodule

// ==== stageId/DecoderRv32i.sv ====
`timescale 1ns/1ps

`include "stageId_macros.svh"

module DecoderRv32i
    import rv32iPkg::*;
(
    input  logic [31:0]            i_Inst,
    output OpCode                  o_Op,
    output logic [`REG_WIDTH-1:0]  o_Rs1,
    output logic [`REG_WIDTH-1:0]  o_Rs2,
    output logic [`REG_WIDTH-1:0]  o_Rd,
    output logic [`DATA_WIDTH-1:0] o_Imm        // Sign-extended immediate
);

    logic sign;                                 // Bit 31 is the sign of every format

    assign sign  = i_Inst[31];
    assign o_Op  = OpCode'(i_Inst[6:0]);
    assign o_Rs1 = i_Inst[19:15];
    assign o_Rs2 = i_Inst[24:20];

    always_comb begin
        o_Rd  = i_Inst[11:7];
        o_Imm = '0;                             // R-type and unknown
        case (o_Op)
            OP_LOAD, OP_OPIMM, OP_JALR:         // I-type
                o_Imm = {{20{sign}}, i_Inst[31:20]};
            OP_STORE: begin                     // S-type
                o_Imm = {{20{sign}}, i_Inst[31:25], i_Inst[11:7]};
                o_Rd  = '0;                     // No destination
            end
            OP_BRANCH: begin                    // B-type
                o_Imm = {{19{sign}}, sign, i_Inst[7], i_Inst[30:25],
                         i_Inst[11:8], 1'b0};
                o_Rd  = '0;
            end
            OP_LUI, OP_AUIPC:                   // U-type
                o_Imm = {i_Inst[31:12], 12'b0};
            OP_JAL:                             // J-type
                o_Imm = {{11{sign}}, sign, i_Inst[19:12], i_Inst[20],
                         i_Inst[30:21], 1'b0};
            default: o_Imm = '0;
        endcase
    end

endmodule

// ==== stageId/ControllerRv32i.sv ====
`timescale 1ns/1ps

module ControllerRv32i
    import rv32iPkg::*;
(
    input  logic [31:0] i_Inst,
    input  logic        i_IsEq,                 // rs1 == rs2
    input  logic        i_IsLt,                 // rs1 < rs2
    output logic        o_Unsigned,             // BLTU and BGEU compare
    output CtrlWord     o_Ctrl,
    output PcNextSel    o_PcNextSel
);

    OpCode      op;
    logic [2:0] funct3;
    logic       funct7b5;                       // SUB and SRA select
    logic       cond;                           // Raw compare for funct3
    logic       taken;                          // Branch resolved
    AluOp       aluFunct;                       // ALU op from funct3

    assign op         = OpCode'(i_Inst[6:0]);
    assign funct3     = i_Inst[14:12];
    assign funct7b5   = i_Inst[30];
    assign o_Unsigned = (op == OP_BRANCH) && funct3[1];

    // ------------------------------
    // Branch condition
    // ------------------------------
    assign cond  = funct3[2] ? i_IsLt : i_IsEq;
    assign taken = (funct3[2:1] != 2'b01) && (cond ^ funct3[0]);  // 010 and 011 never

    always_comb begin
        case (funct3)
            3'b000:  aluFunct = (op == OP_OP && funct7b5) ? ALU_SUB : ALU_ADD;
            3'b001:  aluFunct = ALU_SLL;
            3'b010:  aluFunct = ALU_SLT;
            3'b011:  aluFunct = ALU_SLTU;
            3'b100:  aluFunct = ALU_XOR;
            3'b101:  aluFunct = funct7b5 ? ALU_SRA : ALU_SRL;
            3'b110:  aluFunct = ALU_OR;
            default: aluFunct = ALU_AND;
        endcase
    end

    // ------------------------------
    // Control word per opcode
    // ------------------------------
    always_comb begin
        o_Ctrl      = '0;                       // No writes, WB_ALU, ADD
        o_PcNextSel = PC_SEQ;
        case (op)
            OP_LUI: begin
                o_Ctrl.regWrEnable = 1'b1;
                o_Ctrl.operandBSel = 1'b1;
                o_Ctrl.aluOp       = ALU_PASSB;
            end
            OP_AUIPC: begin
                o_Ctrl.regWrEnable = 1'b1;
                o_Ctrl.operandASel = 1'b1;      // PC + imm
                o_Ctrl.operandBSel = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                o_Ctrl.regWrEnable  = 1'b1;
                o_Ctrl.regWrDataSel = WB_PC4;   // Link
                o_PcNextSel = (op == OP_JAL) ? PC_OFFSET : PC_REG;
            end
            OP_BRANCH: begin
                o_Ctrl.aluOp = ALU_SUB;
                o_PcNextSel  = taken ? PC_OFFSET : PC_SEQ;
            end
            OP_LOAD: begin
                o_Ctrl.regWrEnable  = 1'b1;
                o_Ctrl.regWrDataSel = WB_MEM;
                o_Ctrl.operandBSel  = 1'b1;     // Address rs1 + imm
            end
            OP_STORE: begin
                o_Ctrl.memWrEnable = 1'b1;
                o_Ctrl.operandBSel = 1'b1;
            end
            OP_OPIMM: begin
                o_Ctrl.regWrEnable = 1'b1;
                o_Ctrl.operandBSel = 1'b1;
                o_Ctrl.aluOp       = aluFunct;
            end
            OP_OP: begin
                o_Ctrl.regWrEnable = 1'b1;
                o_Ctrl.aluOp       = aluFunct;
            end
            default: o_PcNextSel = PC_SEQ;      // CSR, fence, system are no-ops
        endcase
    end

endmodule

// ==== stageId/IdForwardController.sv ====
`timescale 1ns/1ps

`include "stageId_macros.svh"

module IdForwardController
    import rv32iPkg::*;
    import pipePkg::*;
(
    input  logic [`REG_WIDTH-1:0] i_Rs1,
    input  logic [`REG_WIDTH-1:0] i_Rs2,
    input  logic                  i_IdExRegWrEnable,
    input  logic [`REG_WIDTH-1:0] i_IdExRegWrAddr,
    input  RegWrDataSel           i_IdExRegWrDataSel,
    input  logic                  i_ExMemRegWrEnable,
    input  logic [`REG_WIDTH-1:0] i_ExMemRegWrAddr,
    input  logic                  i_MemWbRegWrEnable,
    input  logic [`REG_WIDTH-1:0] i_MemWbRegWrAddr,
    output FwdSel                 o_DataASel,
    output FwdSel                 o_DataBSel
);

    // Youngest writer wins, x0 never forwards
    function automatic FwdSel pickSource(input logic [`REG_WIDTH-1:0] rs);
        if (rs == '0)
            return FWD_REGS;
        if (i_IdExRegWrEnable && i_IdExRegWrAddr == rs && i_IdExRegWrDataSel == WB_ALU)
            return FWD_EX;                      // Loads in EX fall through
        if (i_ExMemRegWrEnable && i_ExMemRegWrAddr == rs)
            return FWD_MEM;
        if (i_MemWbRegWrEnable && i_MemWbRegWrAddr == rs)
            return FWD_WB;                      // Same-cycle register write
        return FWD_REGS;
    endfunction

    always_comb begin
        o_DataASel = pickSource(i_Rs1);
        o_DataBSel = pickSource(i_Rs2);
    end

endmodule

// ==== stageId/RegisterFile.sv ====
`timescale 1ns/1ps

`include "stageId_macros.svh"

module RegisterFile (
    input  logic                   i_Clock,
    input  logic                   i_rstN,
    input  logic                   i_WrEnable,
    input  logic [`REG_WIDTH-1:0]  i_WrAddr,
    input  logic [`DATA_WIDTH-1:0] i_WrData,
    input  logic [`REG_WIDTH-1:0]  i_RdAddrA,
    input  logic [`REG_WIDTH-1:0]  i_RdAddrB,
    output logic [`DATA_WIDTH-1:0] o_RdDataA,
    output logic [`DATA_WIDTH-1:0] o_RdDataB
);

    logic [`DATA_WIDTH-1:0] regs [1 << `REG_WIDTH];    // x0 stays at zero

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            for (int i = 0; i < (1 << `REG_WIDTH); i++)
                regs[i] <= '0;
        end else if (i_WrEnable && i_WrAddr != '0) begin
            regs[i_WrAddr] <= i_WrData;        // x0 writes dropped
        end
    end

    assign o_RdDataA = regs[i_RdAddrA];         // Asynchronous reads
    assign o_RdDataB = regs[i_RdAddrB];

endmodule

// ==== stageId/StageID.sv ====
`timescale 1ns/1ps

`include "stageId_macros.svh"

module StageID
    import rv32iPkg::*;
    import pipePkg::*;
(
    input  logic                   i_Clock,
    input  logic                   i_rstN,
    input  IfIdPayload             i_IfId,
    input  logic                   i_IdExRegWrEnable,    // Writer now in ID/EX
    input  logic [`REG_WIDTH-1:0]  i_IdExRegWrAddr,
    input  RegWrDataSel            i_IdExRegWrDataSel,
    input  logic [`DATA_WIDTH-1:0] i_ExData,
    input  StageWrite              i_ExMem,
    input  StageWrite              i_MemWb,              // Also the write port
    output IdExPayload             o_IdEx,
    output logic [`PC_WIDTH-1:0]   o_PCNext,
    output logic                   o_Taken               // Branch taken or jump
);

    OpCode                  decOp;
    logic [`REG_WIDTH-1:0]  decRs1;
    logic [`REG_WIDTH-1:0]  decRs2;
    logic [`REG_WIDTH-1:0]  decRd;
    logic [`DATA_WIDTH-1:0] decImm;
    CtrlWord                ctrl;
    PcNextSel               pcNextSel;
    logic                   isUnsigned;
    logic                   isEq;
    logic                   isLt;
    logic [`DATA_WIDTH-1:0] regDataA;
    logic [`DATA_WIDTH-1:0] regDataB;
    FwdSel                  fwdSelA;
    FwdSel                  fwdSelB;
    logic [`DATA_WIDTH-1:0] cmpA;                       // Forwarded operands
    logic [`DATA_WIDTH-1:0] cmpB;
    logic [`DATA_WIDTH-1:0] jalrSum;                    // rs1 + imm, unforwarded

    DecoderRv32i u_decoder (
        .i_Inst (i_IfId.inst),
        .o_Op   (decOp),
        .o_Rs1  (decRs1),
        .o_Rs2  (decRs2),
        .o_Rd   (decRd),
        .o_Imm  (decImm));

    ControllerRv32i u_controller (
        .i_Inst      (i_IfId.inst),
        .i_IsEq      (isEq),
        .i_IsLt      (isLt),
        .o_Unsigned  (isUnsigned),
        .o_Ctrl      (ctrl),
        .o_PcNextSel (pcNextSel));

    RegisterFile u_regs (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_WrEnable (i_MemWb.regWrEnable),
        .i_WrAddr   (i_MemWb.regWrAddr),
        .i_WrData   (i_MemWb.regWrData),
        .i_RdAddrA  (decRs1),
        .i_RdAddrB  (decRs2),
        .o_RdDataA  (regDataA),
        .o_RdDataB  (regDataB));

    IdForwardController u_fwd (
        .i_Rs1              (decRs1),
        .i_Rs2              (decRs2),
        .i_IdExRegWrEnable  (i_IdExRegWrEnable),
        .i_IdExRegWrAddr    (i_IdExRegWrAddr),
        .i_IdExRegWrDataSel (i_IdExRegWrDataSel),
        .i_ExMemRegWrEnable (i_ExMem.regWrEnable),
        .i_ExMemRegWrAddr   (i_ExMem.regWrAddr),
        .i_MemWbRegWrEnable (i_MemWb.regWrEnable),
        .i_MemWbRegWrAddr   (i_MemWb.regWrAddr),
        .o_DataASel         (fwdSelA),
        .o_DataBSel         (fwdSelB));

    // ------------------------------
    // Forwarding and comparator
    // ------------------------------
    function automatic logic [`DATA_WIDTH-1:0] fwdMux(input FwdSel sel,
                                                      input logic [`DATA_WIDTH-1:0] regData);
        case (sel)
            FWD_EX:  return i_ExData;
            FWD_MEM: return i_ExMem.regWrData;
            FWD_WB:  return i_MemWb.regWrData;
            default: return regData;
        endcase
    endfunction

    always_comb begin
        cmpA = fwdMux(fwdSelA, regDataA);
        cmpB = fwdMux(fwdSelB, regDataB);
    end

    assign isEq = (cmpA == cmpB);
    assign isLt = isUnsigned ? (cmpA < cmpB) : ($signed(cmpA) < $signed(cmpB));

    // ------------------------------
    // Next PC
    // ------------------------------
    assign jalrSum = regDataA + decImm;
    assign o_Taken = i_IfId.valid && (pcNextSel != PC_SEQ);

    always_comb begin
        o_PCNext = i_IfId.pc + `PC_WIDTH'd4;               // Also for an empty slot
        if (i_IfId.valid) begin
            case (pcNextSel)
                PC_OFFSET: o_PCNext = i_IfId.pc + decImm;
                PC_REG:    o_PCNext = {jalrSum[`PC_WIDTH-1:1], 1'b0};
                default:   o_PCNext = i_IfId.pc + `PC_WIDTH'd4;
            endcase
        end
    end

    // Bundle for ID/EX, control zeroed in a bubble
    always_comb begin
        o_IdEx.valid  = i_IfId.valid;
        o_IdEx.opcode = decOp;
        o_IdEx.rs1    = decRs1;
        o_IdEx.rs2    = decRs2;
        o_IdEx.rd     = decRd;
        o_IdEx.imm    = decImm;
        o_IdEx.dataA  = regDataA;
        o_IdEx.dataB  = regDataB;
        o_IdEx.pc     = i_IfId.pc;
        o_IdEx.ctrl   = ctrl;
        if (!i_IfId.valid)
            o_IdEx.ctrl = '0;
    end

endmodule

// ==== design/DecodeTop.sv ====
`timescale 1ns/1ps

`include "stageId_macros.svh"

module DecodeTop
    import pipePkg::*;
(
    input  logic                   i_Clock,
    input  logic                   i_rstN,
    input  logic                   i_Stall,     // Holds both registers
    input  IfIdPayload             i_IfId,      // From fetch
    input  logic [`DATA_WIDTH-1:0] i_ExData,    // EX result
    input  StageWrite              i_ExMem,     // MEM-stage writer
    input  StageWrite              i_MemWb,     // Writeback port
    output IdExPayload             o_IdEx,      // To execute
    output logic [`PC_WIDTH-1:0]   o_PCNext,
    output logic                   o_Taken      // Redirect away from PC + 4
);

    IfIdPayload ifId;                           // IF/ID contents
    IdExPayload idExNext;                       // Decoded bundle

    PipelineReg #(.PayloadT(IfIdPayload)) IfIdReg (
        .i_Clock (i_Clock),
        .i_rstN  (i_rstN),
        .i_Hold  (i_Stall),
        .i_Data  (i_IfId),
        .o_Data  (ifId));

    // ID/EX writer fed back for the forwarding decision
    StageID u_stageId (
        .i_Clock            (i_Clock),
        .i_rstN             (i_rstN),
        .i_IfId             (ifId),
        .i_IdExRegWrEnable  (o_IdEx.ctrl.regWrEnable),
        .i_IdExRegWrAddr    (o_IdEx.rd),
        .i_IdExRegWrDataSel (o_IdEx.ctrl.regWrDataSel),
        .i_ExData           (i_ExData),
        .i_ExMem            (i_ExMem),
        .i_MemWb            (i_MemWb),
        .o_IdEx             (idExNext),
        .o_PCNext           (o_PCNext),
        .o_Taken            (o_Taken));

    PipelineReg #(.PayloadT(IdExPayload)) IdExReg (
        .i_Clock (i_Clock),
        .i_rstN  (i_rstN),
        .i_Hold  (i_Stall),
        .i_Data  (idExNext),
        .o_Data  (o_IdEx));

endmodule

// ==== sim/tbDecodeTop.sv ====
`timescale 1ns/1ps

`include "stageId_macros.svh"

module tbDecodeTop
    import rv32iPkg::*;
    import pipePkg::*;
;

    localparam int NUM_VECTORS = 600;                   // Stimulus cycles
    localparam int CYCLE_LIMIT = 2 + NUM_VECTORS + 4 + 50;

    logic                   i_Clock = 1'b0;
    logic                   i_rstN;
    logic                   i_Stall;
    IfIdPayload             i_IfId;
    logic [`DATA_WIDTH-1:0] i_ExData;
    StageWrite              i_ExMem;
    StageWrite              i_MemWb;
    IdExPayload             o_IdEx;
    logic [`PC_WIDTH-1:0]   o_PCNext;
    logic                   o_Taken;

    logic [31:0]            lfsrState = 32'h320e_3910;
    int                     valueErrors = 0;
    int                     missingErrors = 0;
    int                     cycleCount = 0;
    logic [`DATA_WIDTH-1:0] modelRegs [32];             // Register file model
    IfIdPayload             mIf;                        // Mirror of IF/ID
    IdExPayload             mEx;                        // Expected o_IdEx
    logic [`PC_WIDTH-1:0]   expPcNext;
    logic                   expTaken;

    DecodeTop u_dut (.*);

    always #4 i_Clock = ~i_Clock;                       // 8 ns period

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    function logic [31:0] lfsrBits(input int n);        // One LFSR step per bit
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return v;
    endfunction

    function logic [31:0] randomInst();
        logic [31:0] r;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        r = lfsrBits(4);
        case (r[3:0])
            4'd0:           op = OP_LUI;
            4'd1:           op = OP_AUIPC;
            4'd2:           op = OP_JAL;
            4'd3, 4'd4:     op = OP_JALR;
            4'd5, 4'd6:     op = OP_LOAD;
            4'd7:           op = OP_STORE;
            4'd8, 4'd9:     op = OP_OPIMM;
            4'd10, 4'd11:   op = OP_OP;
            4'd15:          op = 7'b1110011;            // System opcode decodes as a no-op
            default:        op = OP_BRANCH;
        endcase
        r   = lfsrBits(2);
        rs1 = {3'b0, r[1:0]};                           // Few registers so hazards are frequent
        r   = lfsrBits(2);
        rs2 = {3'b0, r[1:0]};
        r   = lfsrBits(3);
        rd  = {2'b0, r[2:0]};
        r   = lfsrBits(3);
        f3  = r[2:0];
        r   = lfsrBits(7);
        f7  = r[6:0];
        if (op == OP_OP)
            f7 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[0], 5'b0} : 7'b0;
        if (op == OP_OPIMM && f3 == 3'd1)
            f7 = 7'b0;
        if (op == OP_OPIMM && f3 == 3'd5)
            f7 = {1'b0, r[0], 5'b0};
        if (op == OP_BRANCH && f3[2:1] == 2'b01)
            f3[1] = 1'b0;                               // Legal funct3 only
        if (op == OP_JALR)
            f3 = 3'd0;
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic CtrlWord controlWordFor(input logic [31:0] inst);
        CtrlWord    c;
        logic [6:0] op;
        AluOp       f;
        op = inst[6:0];
        c  = '0;
        case (inst[14:12])
            3'd0:    f = (op == OP_OP && inst[30]) ? ALU_SUB : ALU_ADD;
            3'd1:    f = ALU_SLL;
            3'd2:    f = ALU_SLT;
            3'd3:    f = ALU_SLTU;
            3'd4:    f = ALU_XOR;
            3'd5:    f = inst[30] ? ALU_SRA : ALU_SRL;
            3'd6:    f = ALU_OR;
            default: f = ALU_AND;
        endcase
        case (op)
            OP_LUI: begin
                c.regWrEnable = 1'b1;
                c.operandBSel = 1'b1;
                c.aluOp       = ALU_PASSB;
            end
            OP_AUIPC: begin
                c.regWrEnable = 1'b1;
                c.operandASel = 1'b1;
                c.operandBSel = 1'b1;
            end
            OP_JAL,
            OP_JALR: begin
                c.regWrEnable  = 1'b1;
                c.regWrDataSel = WB_PC4;
            end
            OP_BRANCH:
                c.aluOp = ALU_SUB;
            OP_LOAD: begin
                c.regWrEnable  = 1'b1;
                c.regWrDataSel = WB_MEM;
                c.operandBSel  = 1'b1;
            end
            OP_STORE: begin
                c.memWrEnable = 1'b1;
                c.operandBSel = 1'b1;
            end
            OP_OPIMM: begin
                c.regWrEnable = 1'b1;
                c.operandBSel = 1'b1;
                c.aluOp       = f;
            end
            OP_OP: begin
                c.regWrEnable = 1'b1;
                c.aluOp       = f;
            end
            default:
                c = '0;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] immediateFor(input logic [31:0] inst);
        case (inst[6:0])
            OP_LOAD, OP_OPIMM, OP_JALR: return 32'($signed(inst[31:20]));
            OP_STORE:  return 32'($signed({inst[31:25], inst[11:7]}));
            OP_BRANCH: return 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
            OP_LUI, OP_AUIPC: return {inst[31:12], 12'h000};
            OP_JAL:    return 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
            default:   return 32'h0;
        endcase
    endfunction

    function IdExPayload expectedBundle(input IfIdPayload p);
        IdExPayload e;
        e.valid  = p.valid;
        e.opcode = OpCode'(p.inst[6:0]);
        e.rs1    = p.inst[19:15];
        e.rs2    = p.inst[24:20];
        e.rd     = (p.inst[6:0] == OP_STORE || p.inst[6:0] == OP_BRANCH) ? 5'd0 : p.inst[11:7];
        e.imm    = immediateFor(p.inst);
        e.dataA  = modelRegs[p.inst[19:15]];
        e.dataB  = modelRegs[p.inst[24:20]];
        e.pc     = p.pc;
        e.ctrl   = p.valid ? controlWordFor(p.inst) : '0;   // Bubble carries no control
        return e;
    endfunction

    function logic [31:0] forwardedValue(input logic [4:0] rs);    // EX before MEM before WB
        if (rs == 5'd0)
            return modelRegs[0];
        if (mEx.ctrl.regWrEnable && mEx.rd == rs && mEx.ctrl.regWrDataSel == WB_ALU)
            return i_ExData;
        if (i_ExMem.regWrEnable && i_ExMem.regWrAddr == rs)
            return i_ExMem.regWrData;
        if (i_MemWb.regWrEnable && i_MemWb.regWrAddr == rs)
            return i_MemWb.regWrData;
        return modelRegs[rs];
    endfunction

    always_comb begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        br;
        a   = forwardedValue(mIf.inst[19:15]);
        b   = forwardedValue(mIf.inst[24:20]);
        imm = immediateFor(mIf.inst);
        case (mIf.inst[14:12])
            3'd0:    br = (a == b);
            3'd1:    br = (a != b);
            3'd4:    br = ($signed(a) < $signed(b));
            3'd5:    br = ($signed(a) >= $signed(b));
            3'd6:    br = (a < b);
            default: br = (a >= b);
        endcase
        expTaken  = 1'b0;
        expPcNext = mIf.pc + 32'd4;
        if (mIf.valid && (mIf.inst[6:0] == OP_JAL || (mIf.inst[6:0] == OP_BRANCH && br))) begin
            expTaken  = 1'b1;
            expPcNext = mIf.pc + imm;
        end else if (mIf.valid && mIf.inst[6:0] == OP_JALR) begin
            expTaken  = 1'b1;
            expPcNext = (modelRegs[mIf.inst[19:15]] + imm) & 32'hffff_fffe;  // Unforwarded
        end
    end

    always @(posedge i_Clock) begin
        if (!i_rstN) begin
            mIf <= '0;
            mEx <= '0;
            for (int i = 0; i < 32; i++)
                modelRegs[i] <= '0;
        end else begin
            if (!i_Stall) begin
                mIf <= i_IfId;
                mEx <= expectedBundle(mIf);
            end
            if (i_MemWb.regWrEnable && i_MemWb.regWrAddr != 5'd0)
                modelRegs[i_MemWb.regWrAddr] <= i_MemWb.regWrData;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    assert property (@(posedge i_Clock) disable iff (!i_rstN) o_IdEx == mEx)
        else begin
            valueErrors++;
            $display("FAILED o_IdEx exp %h got %h", mEx, o_IdEx);
        end
    assert property (@(posedge i_Clock) disable iff (!i_rstN) o_PCNext == expPcNext)
        else begin
            valueErrors++;
            $display("FAILED o_PCNext exp %h got %h", expPcNext, o_PCNext);
        end
    assert property (@(posedge i_Clock) disable iff (!i_rstN) o_Taken == expTaken)
        else begin
            valueErrors++;
            $display("FAILED o_Taken exp %h got %h", expTaken, o_Taken);
        end
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
                     !o_IdEx.valid |-> !o_IdEx.ctrl.regWrEnable && !o_IdEx.ctrl.memWrEnable)
        else begin
            valueErrors++;
            $display("FAILED o_IdEx.ctrl exp 0 got %h", o_IdEx.ctrl);
        end
    assert property (@(posedge i_Clock) disable iff (!i_rstN) mEx.valid |-> o_IdEx.valid)
        else begin
            missingErrors++;
            $display("Decoded instruction did not arrive on o_IdEx");
        end
    assert property (@(posedge i_Clock) disable iff (!i_rstN) i_Stall |=> $stable(o_IdEx))
        else begin
            valueErrors++;
            $display("FAILED o_IdEx changed under stall, now %h", o_IdEx);
        end

    always @(posedge i_Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        IfIdPayload  p;
        StageWrite   w;
        logic [31:0] r;
        i_rstN   = 1'b0;
        i_Stall  = 1'b0;
        i_IfId   = '0;
        i_ExData = '0;
        i_ExMem  = '0;
        i_MemWb  = '0;
        repeat (2) @(posedge i_Clock);
        i_rstN <= 1'b1;
        for (int n = 0; n < NUM_VECTORS; n++) begin
            @(posedge i_Clock);
            r       = lfsrBits(4);
            p.valid = (r[3:0] != 4'd0);                 // Some bubbles
            p.inst  = randomInst();
            r       = lfsrBits(30);
            p.pc    = {r[29:0], 2'b00};
            i_IfId  <= p;
            r       = lfsrBits(3);
            i_Stall <= (r[2:0] == 3'd0);
            i_ExData <= lfsrBits(32);
            r = lfsrBits(3);
            w = {r[0], 3'b000, r[2:1], lfsrBits(32)};
            i_ExMem <= w;
            r = lfsrBits(4);
            w = {r[0] | r[3], 3'b000, r[2:1], lfsrBits(32)};
            i_MemWb <= w;
        end
        @(posedge i_Clock);
        i_IfId  <= '0;
        i_Stall <= 1'b0;
        i_ExMem <= '0;
        i_MemWb <= '0;
        repeat (3) @(posedge i_Clock);
        @(negedge i_Clock);
        $display("Errors: %0d wrong values, %0d missing items", valueErrors, missingErrors);
        if (valueErrors == 0 && missingErrors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+common
common/rv32iPkg.sv
common/pipePkg.sv
design/PipelineReg.sv
stageId/DecoderRv32i.sv
stageId/ControllerRv32i.sv
stageId/IdForwardController.sv
stageId/RegisterFile.sv
stageId/StageID.sv
design/DecodeTop.sv
sim/tbDecodeTop.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module tbDecodeTop -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
